// File: Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   List these targets"
	@echo "  test   Build and run the testbench with Verilator, pass or fail from sim.log"
	@echo "  clean  Remove the build directory and the log"

test:
	verilator --binary --timing --assert -f flist.f --top-module uart_dbg_tb \
		-Mdir obj_dir -o uart_dbg_sim
	./obj_dir/uart_dbg_sim | tee sim.log
	@grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

// File: flist.f
+incdir+hw
hw/uart_dbg_pkg.sv
hw/baud_timer.sv
hw/uart_rx_frame.sv
hw/uart_tx_frame.sv
hw/dbg_cmd_fsm.sv
hw/uart_dbg_bridge.sv
verification/uart_dbg_properties.sv
verification/uart_dbg_tb.sv

// File: hw/baud_timer.sv
// Baud timer that divides the clock into one tick per UART bit period
`include "uart_dbg_defs.svh"

module baud_timer (
  input  logic clk,
  input  logic rst_n_i,
  input  logic restart_i,
  input  logic half_i,
  output logic tick_o
);

  localparam int unsigned PERIOD = `UART_DBG_CLKS_PER_BIT;
  localparam int unsigned CNT_W  = (PERIOD > 1) ? $clog2(PERIOD) : 1;

  localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(PERIOD - 1);
  localparam logic [CNT_W-1:0] HALF_CNT = CNT_W'(PERIOD / 2);

  logic [CNT_W-1:0] cnt_q;

  // Free running counter, wraps once per bit
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else if (restart_i) begin
      // Half start puts the first tick at mid-bit
      cnt_q <= half_i ? HALF_CNT : '0;
    end else if (cnt_q == LAST_CNT) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // No tick in the restart cycle
  assign tick_o = (cnt_q == LAST_CNT) && !restart_i;

endmodule

// File: hw/dbg_cmd_fsm.sv
// Debug command FSM that decodes host commands and runs byte-wide APB accesses
`include "uart_dbg_defs.svh"

module dbg_cmd_fsm import uart_dbg_pkg::*; (
  input  logic       clk,
  input  logic       rst_n_i,
  input  byte_t      rx_data_i,
  input  logic       rx_valid_i,
  output byte_t      tx_data_o,
  output logic       tx_start_o,
  input  logic       tx_busy_i,
  output logic       psel_o,
  output logic       penable_o,
  output logic       pwrite_o,
  output addr_t      paddr_o,
  output apb_data_t  pwdata_o,
  output logic [3:0] pstrb_o,
  input  apb_data_t  prdata_i,
  input  logic       pready_i
);

  localparam logic [2:0] IDLE            = 3'd0;
  localparam logic [2:0] HEADER          = 3'd1;
  localparam logic [2:0] SEND_ACK        = 3'd2;
  localparam logic [2:0] WRITE_WAIT_BYTE = 3'd3;
  localparam logic [2:0] APB_SETUP       = 3'd4;
  localparam logic [2:0] APB_ACCESS      = 3'd5;
  localparam logic [2:0] SEND_DATA       = 3'd6;
  localparam logic [2:0] SEND_EOT        = 3'd7;

  localparam int unsigned      IDX_W    = $clog2(`UART_DBG_HDR_BYTES);
  localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`UART_DBG_HDR_BYTES - 1);

  logic [2:0]       state_q;
  logic [IDX_W-1:0] hdr_idx_q;
  logic             ping_q;
  logic             pwrite_q;
  dbg_hdr_u         hdr_q;
  byte_t            wbyte_q;
  byte_t            rdata_q;
  logic [1:0]       lane;
  logic             tx_fire;
  logic             apb_done;
  logic             last_byte;
  logic             step;

  assign lane      = hdr_q.fields.addr[1:0];
  assign apb_done  = (state_q == APB_ACCESS) && pready_i;
  assign last_byte = (hdr_q.fields.len == len_t'(1));
  assign tx_fire   = tx_start_o;
  // One byte done, move to the next address
  assign step      = (apb_done && pwrite_q) || ((state_q == SEND_DATA) && tx_fire);

  ////////////////////
  // State register
  ////////////////////

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q   <= IDLE;
      hdr_idx_q <= '0;
      ping_q    <= 1'b0;
      pwrite_q  <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (rx_valid_i) begin
            hdr_idx_q <= '0;
            if (rx_data_i == `UART_DBG_ACK) begin
              ping_q  <= 1'b1;
              state_q <= SEND_ACK;
            end else if ((rx_data_i == `UART_DBG_CMD_READ) ||
                         (rx_data_i == `UART_DBG_CMD_WRITE)) begin
              ping_q   <= 1'b0;
              pwrite_q <= (rx_data_i == `UART_DBG_CMD_WRITE);
              state_q  <= HEADER;
            end
          end
        end
        HEADER: begin
          if (rx_valid_i) begin
            hdr_idx_q <= hdr_idx_q + 1'b1;
            if (hdr_idx_q == LAST_IDX) begin
              state_q <= SEND_ACK;
            end
          end
        end
        SEND_ACK: begin
          if (tx_fire) begin
            if (ping_q) begin
              state_q <= IDLE;
            end else if (hdr_q.fields.len == '0) begin
              state_q <= SEND_EOT;
            end else if (pwrite_q) begin
              state_q <= WRITE_WAIT_BYTE;
            end else begin
              state_q <= APB_SETUP;
            end
          end
        end
        WRITE_WAIT_BYTE: begin
          if (rx_valid_i) begin
            state_q <= APB_SETUP;
          end
        end
        APB_SETUP: begin
          state_q <= APB_ACCESS;
        end
        APB_ACCESS: begin
          if (pready_i) begin
            if (!pwrite_q) begin
              state_q <= SEND_DATA;
            end else begin
              state_q <= last_byte ? SEND_EOT : WRITE_WAIT_BYTE;
            end
          end
        end
        SEND_DATA: begin
          if (tx_fire) begin
            state_q <= last_byte ? SEND_EOT : APB_SETUP;
          end
        end
        default: begin
          if (tx_fire) begin
            state_q <= IDLE;
          end
        end
      endcase
    end
  end

  ////////////////////
  // Datapath
  ////////////////////

  // Header is filled bytewise, then counted down through its fields
  always_ff @(posedge clk) begin
    if ((state_q == HEADER) && rx_valid_i) begin
      hdr_q.bytes[hdr_idx_q] <= rx_data_i;
    end
    if (step) begin
      hdr_q.fields.addr <= hdr_q.fields.addr + 1'b1;
      hdr_q.fields.len  <= hdr_q.fields.len - 1'b1;
    end
    if ((state_q == WRITE_WAIT_BYTE) && rx_valid_i) begin
      wbyte_q <= rx_data_i;
    end
    if (apb_done && !pwrite_q) begin
      rdata_q <= prdata_i[8*lane +: 8];
    end
  end

  // Replies
  assign tx_start_o = !tx_busy_i &&
                      ((state_q == SEND_ACK) || (state_q == SEND_DATA) || (state_q == SEND_EOT));

  always_comb begin
    case (state_q)
      SEND_DATA: tx_data_o = rdata_q;
      SEND_EOT:  tx_data_o = `UART_DBG_EOT;
      default:   tx_data_o = `UART_DBG_ACK;
    endcase
  end

  // APB requester, one byte lane per access
  assign psel_o    = (state_q == APB_SETUP) || (state_q == APB_ACCESS);
  assign penable_o = (state_q == APB_ACCESS);
  assign pwrite_o  = pwrite_q;
  assign paddr_o   = {hdr_q.fields.addr[$bits(addr_t)-1:2], 2'b00};
  assign pwdata_o  = {4{wbyte_q}};
  assign pstrb_o   = pwrite_q ? (4'b0001 << lane) : 4'b0000;

endmodule

// File: hw/uart_dbg_bridge.sv
// UART debug bridge top that links the serial frame units to the APB command FSM
module uart_dbg_bridge import uart_dbg_pkg::*; (
  input  logic       clk,
  input  logic       rst_n_i,
  input  logic       uart_rx_i,
  output logic       uart_tx_o,
  output logic       psel_o,
  output logic       penable_o,
  output logic       pwrite_o,
  output addr_t      paddr_o,
  output apb_data_t  pwdata_o,
  output logic [3:0] pstrb_o,
  input  apb_data_t  prdata_i,
  input  logic       pready_i,
  // Error responses are not reported back to the host
  input  logic       pslverr_i
);

  byte_t rx_data;
  logic  rx_valid;
  byte_t tx_data;
  logic  tx_start;
  logic  tx_busy;

  uart_rx_frame i_uart_rx_frame (
    .clk        ( clk       ),
    .rst_n_i    ( rst_n_i   ),
    .uart_rx_i  ( uart_rx_i ),
    .rx_data_o  ( rx_data   ),
    .rx_valid_o ( rx_valid  )
  );

  uart_tx_frame i_uart_tx_frame (
    .clk        ( clk       ),
    .rst_n_i    ( rst_n_i   ),
    .tx_data_i  ( tx_data   ),
    .tx_start_i ( tx_start  ),
    .tx_busy_o  ( tx_busy   ),
    .uart_tx_o  ( uart_tx_o )
  );

  dbg_cmd_fsm i_dbg_cmd_fsm (
    .clk        ( clk       ),
    .rst_n_i    ( rst_n_i   ),
    .rx_data_i  ( rx_data   ),
    .rx_valid_i ( rx_valid  ),
    .tx_data_o  ( tx_data   ),
    .tx_start_o ( tx_start  ),
    .tx_busy_i  ( tx_busy   ),
    .psel_o     ( psel_o    ),
    .penable_o  ( penable_o ),
    .pwrite_o   ( pwrite_o  ),
    .paddr_o    ( paddr_o   ),
    .pwdata_o   ( pwdata_o  ),
    .pstrb_o    ( pstrb_o   ),
    .prdata_i   ( prdata_i  ),
    .pready_i   ( pready_i  )
  );

endmodule

// File: hw/uart_dbg_defs.svh
// UART debug bridge constants: bit timing, host command codes and field widths
`ifndef UART_DBG_DEFS_SVH
`define UART_DBG_DEFS_SVH

////////////////////
// Bit timing
////////////////////

// Clock cycles per UART bit
`define UART_DBG_CLKS_PER_BIT 16

////////////////////
// Command codes
////////////////////

`define UART_DBG_CMD_READ  8'h11
`define UART_DBG_CMD_WRITE 8'h12
`define UART_DBG_ACK       8'h06
`define UART_DBG_EOT       8'h04

// Four address bytes, then two length bytes, all LSB first
`define UART_DBG_HDR_BYTES 6

////////////////////
// Widths
////////////////////

`define UART_DBG_BYTE_W     8
`define UART_DBG_ADDR_W     32
`define UART_DBG_LEN_W      16
`define UART_DBG_APB_DATA_W 32

`endif

// File: hw/uart_dbg_pkg.sv
// UART debug bridge package with the byte, address, length and header types
`include "uart_dbg_defs.svh"

package uart_dbg_pkg;

  // One UART payload byte
  typedef logic [`UART_DBG_BYTE_W-1:0] byte_t;

  // APB byte address
  typedef logic [`UART_DBG_ADDR_W-1:0] addr_t;

  // Transfer length in bytes
  typedef logic [`UART_DBG_LEN_W-1:0] len_t;

  // APB data word
  typedef logic [`UART_DBG_APB_DATA_W-1:0] apb_data_t;

  // Header as the FSM uses it
  // Address sits in the low bits, since it arrives first
  typedef struct packed {
    len_t  len;
    addr_t addr;
  } dbg_hdr_fields_t;

  // Same 48 bits, filled one received byte at a time
  typedef union packed {
    byte_t [`UART_DBG_HDR_BYTES-1:0] bytes;
    dbg_hdr_fields_t                 fields;
  } dbg_hdr_u;

endpackage

// File: hw/uart_rx_frame.sv
// UART receiver that turns 8N1 frames into bytes with a one-cycle valid pulse
module uart_rx_frame import uart_dbg_pkg::*; (
  input  logic  clk,
  input  logic  rst_n_i,
  input  logic  uart_rx_i,
  output byte_t rx_data_o,
  output logic  rx_valid_o
);

  localparam logic [1:0] RX_IDLE  = 2'd0;
  localparam logic [1:0] RX_START = 2'd1;
  localparam logic [1:0] RX_DATA  = 2'd2;
  localparam logic [1:0] RX_STOP  = 2'd3;

  logic [1:0] state_q;
  logic       rx_meta_q;
  logic       rx_sync_q;
  logic       rx_prev_q;
  logic [2:0] bit_cnt_q;
  byte_t      shift_q;
  logic       tick;
  logic       start_edge;

  // Falling edge of the start bit while idle
  assign start_edge = (state_q == RX_IDLE) && rx_prev_q && !rx_sync_q;

  baud_timer i_baud_timer (
    .clk       ( clk        ),
    .rst_n_i   ( rst_n_i    ),
    .restart_i ( start_edge ),
    .half_i    ( 1'b1       ),
    .tick_o    ( tick       )
  );

  ////////////////////
  // Frame control
  ////////////////////

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rx_meta_q  <= 1'b1;
      rx_sync_q  <= 1'b1;
      rx_prev_q  <= 1'b1;
      state_q    <= RX_IDLE;
      bit_cnt_q  <= '0;
      rx_valid_o <= 1'b0;
    end else begin
      rx_meta_q  <= uart_rx_i;
      rx_sync_q  <= rx_meta_q;
      rx_prev_q  <= rx_sync_q;
      rx_valid_o <= 1'b0;
      case (state_q)
        RX_IDLE: begin
          if (start_edge) begin
            state_q <= RX_START;
          end
        end
        RX_START: begin
          if (tick) begin
            bit_cnt_q <= '0;
            // Line back high at mid start bit means a glitch
            state_q   <= rx_sync_q ? RX_IDLE : RX_DATA;
          end
        end
        RX_DATA: begin
          if (tick) begin
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (bit_cnt_q == 3'd7) begin
              state_q <= RX_STOP;
            end
          end
        end
        default: begin
          // Stop bit low drops the frame
          if (tick) begin
            rx_valid_o <= rx_sync_q;
            state_q    <= RX_IDLE;
          end
        end
      endcase
    end
  end

  // Data bits arrive LSB first
  always_ff @(posedge clk) begin
    if ((state_q == RX_DATA) && tick) begin
      shift_q <= {rx_sync_q, shift_q[7:1]};
    end
  end

  assign rx_data_o = shift_q;

endmodule

// File: hw/uart_tx_frame.sv
// UART transmitter that sends one byte as an 8N1 frame and flags busy meanwhile
module uart_tx_frame import uart_dbg_pkg::*; (
  input  logic  clk,
  input  logic  rst_n_i,
  input  byte_t tx_data_i,
  input  logic  tx_start_i,
  output logic  tx_busy_o,
  output logic  uart_tx_o
);

  logic [9:0] shift_q;
  logic [3:0] bit_cnt_q;
  logic       busy_q;
  logic       tick;
  logic       load;

  // A start request while busy is not taken
  assign load = tx_start_i && !busy_q;

  baud_timer i_baud_timer (
    .clk       ( clk     ),
    .rst_n_i   ( rst_n_i ),
    .restart_i ( load    ),
    .half_i    ( 1'b0    ),
    .tick_o    ( tick    )
  );

  ////////////////////
  // Shift register
  ////////////////////

  // Bit 0 drives the line, ones shift in behind the frame
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      shift_q   <= '1;
      bit_cnt_q <= '0;
      busy_q    <= 1'b0;
    end else if (load) begin
      // Stop bit, data LSB first, start bit
      shift_q   <= {1'b1, tx_data_i, 1'b0};
      bit_cnt_q <= '0;
      busy_q    <= 1'b1;
    end else if (busy_q && tick) begin
      shift_q <= {1'b1, shift_q[9:1]};
      // Tenth tick closes the stop bit
      if (bit_cnt_q == 4'd9) begin
        busy_q <= 1'b0;
      end else begin
        bit_cnt_q <= bit_cnt_q + 1'b1;
      end
    end
  end

  assign uart_tx_o = shift_q[0];
  assign tx_busy_o = busy_q;

endmodule

// File: verification/uart_dbg_properties.sv
// APB requester and UART idle line assertions for the UART debug bridge
module uart_dbg_properties import uart_dbg_pkg::*; (
  input logic       clk,
  input logic       rst_n_i,
  input logic       psel_o,
  input logic       penable_o,
  input logic       pwrite_o,
  input addr_t      paddr_o,
  input apb_data_t  pwdata_o,
  input logic [3:0] pstrb_o,
  input logic       pready_i,
  input logic       uart_tx_o
);

  // Access phase always follows a selected cycle
  penable_after_psel: assert property (@(posedge clk) disable iff (!rst_n_i)
    penable_o |-> $past(psel_o))
    else $error("penable_o high without psel_o in the previous cycle");

  // Requester holds everything through a wait state
  hold_in_wait: assert property (@(posedge clk) disable iff (!rst_n_i)
    (psel_o && penable_o && !pready_i) |=>
      (psel_o && penable_o && $stable(paddr_o) && $stable(pwrite_o) &&
       $stable(pwdata_o) && $stable(pstrb_o)))
    else $error("APB outputs changed during a wait state");

  tx_idle_after_reset: assert property (@(posedge clk)
    !rst_n_i |=> uart_tx_o)
    else $error("uart_tx_o not idle high after reset");

endmodule

bind uart_dbg_bridge uart_dbg_properties i_uart_dbg_properties (.*);

// File: verification/uart_dbg_tb.sv
// Testbench for the UART debug bridge with a UART host driver and an APB memory model
`include "uart_dbg_defs.svh"

module uart_dbg_tb import uart_dbg_pkg::*; ();

  localparam int BIT_CLKS      = `UART_DBG_CLKS_PER_BIT;
  localparam int MEM_BYTES     = 64;
  localparam int REPLY_TIMEOUT = 8000;
  localparam int QUIET_CLKS    = 24 * `UART_DBG_CLKS_PER_BIT;
  localparam int WATCHDOG_CLKS = 200000;

  typedef byte_t byte_q_t[$];

  logic       clk;
  logic       rst_n_i;
  logic       uart_rx_i;
  logic       uart_tx_o;
  logic       psel_o;
  logic       penable_o;
  logic       pwrite_o;
  addr_t      paddr_o;
  apb_data_t  pwdata_o;
  logic [3:0] pstrb_o;
  apb_data_t  prdata_i;
  logic       pready_i;
  logic       pslverr_i;

  byte_t      mem [MEM_BYTES];
  byte_t      ref_mem [MEM_BYTES];
  byte_q_t    rx_q;
  addr_t      wr_addr_q [$];
  apb_data_t  wr_data_q [$];
  logic [3:0] wr_strb_q [$];
  int         apb_count;
  integer     seed;
  int         errors;
  int         tests_passed;
  int         tests_failed;
  logic       mon_active;
  int         mon_cnt;
  int         mon_bit;
  byte_t      mon_byte;

  initial clk = 1'b0;
  always #10 clk = ~clk;

  uart_dbg_bridge dut0 (
    .clk       ( clk       ),
    .rst_n_i   ( rst_n_i   ),
    .uart_rx_i ( uart_rx_i ),
    .uart_tx_o ( uart_tx_o ),
    .psel_o    ( psel_o    ),
    .penable_o ( penable_o ),
    .pwrite_o  ( pwrite_o  ),
    .paddr_o   ( paddr_o   ),
    .pwdata_o  ( pwdata_o  ),
    .pstrb_o   ( pstrb_o   ),
    .prdata_i  ( prdata_i  ),
    .pready_i  ( pready_i  ),
    .pslverr_i ( pslverr_i )
  );

  ////////////////////
  // APB completer
  ////////////////////

  always @(posedge clk) begin : apb_model
    logic  sel;
    logic  en;
    logic  rdy;
    addr_t addr;
    int    lane;
    int    wait_left;
    sel  = psel_o;
    en   = penable_o;
    rdy  = pready_i;
    addr = paddr_o;
    if (sel && en && rdy) begin
      apb_count++;
      if (pwrite_o) begin
        wr_addr_q.push_back(paddr_o);
        wr_data_q.push_back(pwdata_o);
        wr_strb_q.push_back(pstrb_o);
        for (lane = 0; lane < 4; lane++) begin
          if (pstrb_o[lane]) mem[{paddr_o[5:2], lane[1:0]}] = pwdata_o[8*lane +: 8];
        end
      end
    end
    #2;
    // Random wait states of 0 to 3 cycles per access
    if (sel && !en) begin
      wait_left = $random(seed) & 3;
      pready_i  = (wait_left == 0);
    end else if (sel && en && !rdy) begin
      wait_left--;
      pready_i = (wait_left == 0);
    end else begin
      pready_i = 1'b0;
    end
    prdata_i = {mem[{addr[5:2], 2'd3}], mem[{addr[5:2], 2'd2}],
                mem[{addr[5:2], 2'd1}], mem[{addr[5:2], 2'd0}]};
  end

  // Reply frames sampled at mid-bit
  always @(posedge clk) begin : tx_monitor
    if (!rst_n_i) begin
      mon_active = 1'b0;
      mon_cnt    = 0;
    end else if (!mon_active) begin
      mon_active = !uart_tx_o;
      mon_cnt    = 0;
    end else begin
      mon_cnt++;
      if ((mon_cnt >= BIT_CLKS / 2) && ((mon_cnt - BIT_CLKS / 2) % BIT_CLKS == 0)) begin
        mon_bit = (mon_cnt - BIT_CLKS / 2) / BIT_CLKS;
        if ((mon_bit == 0) && uart_tx_o) begin
          $display("Start bit on uart_tx_o did not stay low");
          errors++;
          mon_active = 1'b0;
        end else if ((mon_bit >= 1) && (mon_bit <= 8)) begin
          mon_byte[mon_bit-1] = uart_tx_o;
        end else if (mon_bit == 9) begin
          if (uart_tx_o) rx_q.push_back(mon_byte);
          else begin
            $display("Stop bit on uart_tx_o was low");
            errors++;
          end
          mon_active = 1'b0;
        end
      end
    end
  end

  ////////////////////
  // Host side
  ////////////////////

  task automatic send_byte(input byte_t b);
    logic [9:0] frame;
    int         i;
    frame = {1'b1, b, 1'b0};
    for (i = 0; i < 10; i++) begin
      @(posedge clk);
      #2;
      uart_rx_i = frame[i];
      repeat (BIT_CLKS - 1) @(posedge clk);
    end
  endtask

  // Expected reply bytes for one host command
  function automatic byte_q_t expected_reply(input byte_t cmd, input addr_t addr,
                                             input len_t len, input byte_t img [MEM_BYTES]);
    byte_q_t q;
    addr_t   a;
    int      i;
    if (cmd == `UART_DBG_ACK) q.push_back(`UART_DBG_ACK);
    if ((cmd == `UART_DBG_CMD_READ) || (cmd == `UART_DBG_CMD_WRITE)) begin
      q.push_back(`UART_DBG_ACK);
      for (i = 0; (cmd == `UART_DBG_CMD_READ) && (i < int'(len)); i++) begin
        a = addr + addr_t'(i);
        q.push_back(img[a[5:0]]);
      end
      q.push_back(`UART_DBG_EOT);
    end
    return q;
  endfunction

  task automatic check_byte(input byte_t exp, input byte_t act);
    if (exp !== act) begin
      $display("[ERROR] uart_tx_o: expected 0x%02h, got 0x%02h", exp, act);
      errors++;
    end
  endtask

  task automatic check_apb_write(input int idx, input addr_t exp_addr,
                                 input apb_data_t exp_data, input logic [3:0] exp_strb);
    if (wr_addr_q[idx] !== exp_addr) begin
      $display("[ERROR] paddr_o: expected 0x%08h, got 0x%08h", exp_addr, wr_addr_q[idx]);
      errors++;
    end
    if (wr_data_q[idx] !== exp_data) begin
      $display("[ERROR] pwdata_o: expected 0x%08h, got 0x%08h", exp_data, wr_data_q[idx]);
      errors++;
    end
    if (wr_strb_q[idx] !== exp_strb) begin
      $display("[ERROR] pstrb_o: expected 0x%01h, got 0x%01h", exp_strb, wr_strb_q[idx]);
      errors++;
    end
  endtask

  task automatic run_test(input string name, input byte_t cmd, input addr_t addr,
                          input len_t len, input byte_q_t data);
    byte_q_t exp;
    addr_t   a;
    logic    is_cmd;
    int      err_before;
    int      cycles;
    int      i;
    exp        = expected_reply(cmd, addr, len, ref_mem);
    is_cmd     = (cmd == `UART_DBG_CMD_READ) || (cmd == `UART_DBG_CMD_WRITE);
    err_before = errors;
    rx_q.delete();
    wr_addr_q.delete();
    wr_data_q.delete();
    wr_strb_q.delete();
    apb_count = 0;
    send_byte(cmd);
    for (i = 0; is_cmd && (i < 4); i++) send_byte(addr[8*i +: 8]);
    for (i = 0; is_cmd && (i < 2); i++) send_byte(len[8*i +: 8]);
    foreach (data[j]) send_byte(data[j]);
    for (cycles = 0; (rx_q.size() < exp.size()) && (cycles < REPLY_TIMEOUT); cycles++) begin
      @(posedge clk);
    end
    if (rx_q.size() < exp.size()) begin
      $display("Timeout in %s: waited for %0d reply bytes, got %0d", name, exp.size(), rx_q.size());
      $display("Test failed");
      $finish;
    end
    // Any extra reply would show up in this window
    for (cycles = 0; cycles < QUIET_CLKS; cycles++) @(posedge clk);
    if (rx_q.size() != exp.size()) begin
      $display("Reply length wrong in %s: expected %0d bytes, got %0d", name, exp.size(),
               rx_q.size());
      errors++;
    end
    for (i = 0; i < exp.size(); i++) check_byte(exp[i], rx_q[i]);
    if (apb_count != (is_cmd ? int'(len) : 0)) begin
      $display("Wrong number of APB accesses in %s: %0d", name, apb_count);
      errors++;
    end
    if (cmd == `UART_DBG_CMD_WRITE) begin
      for (i = 0; i < int'(len); i++) begin
        a = addr + addr_t'(i);
        ref_mem[a[5:0]] = data[i];
        if (i < wr_addr_q.size()) begin
          check_apb_write(i, {a[31:2], 2'b00}, {4{data[i]}}, 4'b0001 << a[1:0]);
        end
      end
    end else if (wr_addr_q.size() != 0) begin
      $display("APB write seen during %s", name);
      errors++;
    end
    if (errors == err_before) begin
      $display("[PASS] %s", name);
      tests_passed++;
    end else begin
      $display("[FAIL] %s with %0d error(s)", name, errors - err_before);
      tests_failed++;
    end
  endtask

  ////////////////////
  // Test sequence
  ////////////////////

  initial begin : main
    byte_q_t data;
    byte_q_t no_data;
    int      i;
    seed         = 32'h773d_d688;
    rst_n_i      = 1'b0;
    uart_rx_i    = 1'b1;
    prdata_i     = '0;
    pready_i     = 1'b0;
    pslverr_i    = 1'b0;
    errors       = 0;
    tests_passed = 0;
    tests_failed = 0;
    for (i = 0; i < MEM_BYTES; i++) begin
      mem[i]     = byte_t'(i * 37 + 8'h3c);
      ref_mem[i] = mem[i];
    end
    repeat (4) @(posedge clk);
    #2;
    rst_n_i = 1'b1;
    repeat (4) @(posedge clk);
    run_test("ack challenge", `UART_DBG_ACK, '0, '0, no_data);
    for (i = 0; i < 5; i++) data.push_back(byte_t'($random(seed)));
    run_test("write 5 bytes unaligned", `UART_DBG_CMD_WRITE, 32'h0000_0013, 16'd5, data);
    run_test("read 6 bytes preloaded", `UART_DBG_CMD_READ, 32'h0000_0022, 16'd6, no_data);
    data.delete();
    for (i = 0; i < 4; i++) data.push_back(byte_t'($random(seed)));
    run_test("write across word boundary", `UART_DBG_CMD_WRITE, 32'h0000_002e, 16'd4, data);
    run_test("read back written bytes", `UART_DBG_CMD_READ, 32'h0000_002e, 16'd4, no_data);
    run_test("zero length write", `UART_DBG_CMD_WRITE, 32'h0000_0010, 16'd0, no_data);
    run_test("zero length read", `UART_DBG_CMD_READ, 32'h0000_0010, 16'd0, no_data);
    run_test("unknown byte ignored", 8'h55, '0, '0, no_data);
    run_test("ack after unknown byte", `UART_DBG_ACK, '0, '0, no_data);
    $display("Summary: %0d passed, %0d failed, %0d errors", tests_passed, tests_failed, errors);
    if ((errors == 0) && (tests_failed == 0)) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin : watchdog
    int cycles;
    for (cycles = 0; cycles < WATCHDOG_CLKS; cycles++) @(posedge clk);
    $display("Simulation ran past its cycle limit");
    $display("Test failed");
    $finish;
  end

endmodule
